/* bench/clockGenerator.sv */
`timescale 1ns/1ns

module clockGenerator(
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// reset held for ten rising edges
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
	end
endmodule : clockGenerator

/* bench/coherentCache_props.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module coherentCacheProps(
	input logic clock, reset,
	input logic cpuRead, cpuWrite,
	input logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input logic cpuDone,
	input logic busRequest, busGrant, busValid, busCredit
);
	int available;
	logic requestSeen, lastValid, begins;
	logic [`LINE_ADDRESS_WIDTH - 1 : 0] lastLine;

	// credits the node should still hold
	always_ff @(posedge clock) begin
		if (reset) begin
			available <= `BUS_CREDITS;
			requestSeen <= 1'b0;
			lastValid <= 1'b0;
			lastLine <= '0;
		end else begin
			available <= available + int'(busCredit) - int'(busValid);
			requestSeen <= cpuRead || cpuWrite;
			if (cpuDone) begin
				lastLine <= cpuAddress[`ADDRESS_WIDTH - 1 : `OFFSET_WIDTH];
				lastValid <= 1'b1;
			end
		end
	end

	assign begins = (cpuRead || cpuWrite) && !requestSeen;

	validNeedsCredit: assert property (@(posedge clock) disable iff (reset)
		busValid |-> available > 0) else $error("word request sent without a credit");

	validNeedsGrant: assert property (@(posedge clock) disable iff (reset)
		busValid |-> busGrant) else $error("word request sent without a bus grant");

	donePulse: assert property (@(posedge clock) disable iff (reset)
		cpuDone |=> !cpuDone) else $error("cpuDone held longer than one cycle");

	// a read of the line just used must hit
	repeatHit: assert property (@(posedge clock) disable iff (reset)
		begins && cpuRead && lastValid
		&& cpuAddress[`ADDRESS_WIDTH - 1 : `OFFSET_WIDTH] == lastLine |-> ##2 cpuDone)
		else $error("repeat access did not complete as a two cycle hit");

	quietInReset: assert property (@(posedge clock)
		reset |=> !cpuDone && !busRequest && !busValid)
		else $error("outputs active during reset");
endmodule : coherentCacheProps

/* bench/coherentCache_tb.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module coherentCache_tb;
	localparam int DIRECTED_OPERATIONS = 9;
	localparam int RANDOM_OPERATIONS = 40;
	localparam int OPERATIONS = DIRECTED_OPERATIONS + RANDOM_OPERATIONS;
	localparam int CYCLES_PER_OPERATION = 200;

	logic clock, reset;
	logic cpuRead = 1'b0;
	logic cpuWrite = 1'b0;
	logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress = '0;
	logic [`DATA_WIDTH - 1 : 0] cpuWriteData = '0;
	logic busGrant = 1'b0;
	logic busCredit = 1'b0;
	logic busReadValid = 1'b0;
	logic [`DATA_WIDTH - 1 : 0] busReadData = '0;
	logic invalidateAck = 1'b0;
	logic [`DATA_WIDTH - 1 : 0] cpuReadData, busWriteData;
	logic [`ADDRESS_WIDTH - 1 : 0] busAddress;
	logic cpuDone, busRequest, busValid;
	cachePackage::BusCommand busCommand;

	int seed = 32'hfa8d0753;
	logic [`DATA_WIDTH - 1 : 0] memory [1 << `ADDRESS_WIDTH];
	logic [`DATA_WIDTH - 1 : 0] shadow [1 << `ADDRESS_WIDTH];
	logic [`TAG_WIDTH - 1 : 0] refTags [`LINE_COUNT];
	cachePackage::LineState refStates [`LINE_COUNT];
	logic [`ADDRESS_WIDTH - 1 : 0] readQueue [$];
	int readTotal = 0;
	int writebackTotal = 0;
	int ackTotal = 0;
	int pendingCredits = 0;
	int creditDelay = 0;
	int readDelay = 0;
	int grantDelay = 0;
	int ackDelay = 0;
	logic ackSent = 1'b0;

	clockGenerator clocks(.clock(clock), .reset(reset));

	coherentCache uut(.*);

	bind coherentCache coherentCacheProps props(
		.clock(clock), .reset(reset), .cpuRead(cpuRead), .cpuWrite(cpuWrite),
		.cpuAddress(cpuAddress), .cpuDone(cpuDone), .busRequest(busRequest),
		.busGrant(busGrant), .busValid(busValid), .busCredit(busCredit)
	);

	function automatic logic [`DATA_WIDTH - 1 : 0] pattern(input logic [15:0] address);
		return {address[7:0], address[15:8]} ^ 16'hc3a5;
	endfunction

	function automatic int randomDelay();
		return int'($unsigned($random(seed)) % 5);
	endfunction

	task automatic failRun(input string message);
		$display("%s", message);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// arbiter, memory and invalidate acknowledgement
	always @(posedge clock) begin
		if (reset) begin
			readQueue.delete();
			pendingCredits = 0;
			ackSent = 1'b0;
			busGrant <= 1'b0;
			busCredit <= 1'b0;
			busReadValid <= 1'b0;
			invalidateAck <= 1'b0;
		end else begin
			busCredit <= 1'b0;
			busReadValid <= 1'b0;
			invalidateAck <= 1'b0;
			if (invalidateAck) ackTotal++;
			if (!busRequest) begin
				busGrant <= 1'b0;
				ackSent = 1'b0;
				grantDelay = randomDelay();
			end else if (!busGrant) begin
				if (grantDelay == 0) busGrant <= 1'b1;
				else grantDelay--;
			end
			if (busValid) begin
				pendingCredits++;
				if (busCommand == cachePackage::BUS_READ) begin
					readTotal++;
					assert (busAddress[15:2] == cpuAddress[15:2]) else failRun($sformatf(
						"[FAIL] busAddress %h outside line of %h", busAddress, cpuAddress));
					readQueue.push_back(busAddress);
				end else begin
					writebackTotal++;
					assert (busWriteData == shadow[busAddress]) else failRun($sformatf(
						"[FAIL] busWriteData at %h got %h expected %h",
						busAddress, busWriteData, shadow[busAddress]));
					memory[busAddress] = busWriteData;
				end
			end
			if (pendingCredits > 0) begin
				if (creditDelay == 0) begin
					busCredit <= 1'b1;
					pendingCredits--;
					creditDelay = randomDelay();
				end else creditDelay--;
			end
			if (readQueue.size() > 0) begin
				if (readDelay == 0) begin
					busReadValid <= 1'b1;
					busReadData <= memory[readQueue.pop_front()];
					readDelay = randomDelay();
				end else readDelay--;
			end
			if (busGrant && busCommand == cachePackage::BUS_INVALIDATE && !ackSent) begin
				if (ackDelay == 0) begin
					invalidateAck <= 1'b1;
					ackSent = 1'b1;
					ackDelay = randomDelay();
				end else ackDelay--;
			end
		end
	end

	task automatic runOperation(input logic write, input logic [15:0] address,
			input logic [15:0] data);
		logic [`INDEX_WIDTH - 1 : 0] index;
		logic [`TAG_WIDTH - 1 : 0] tag;
		logic hit;
		int startReads, startWritebacks, startAcks, expReads, expWritebacks, expAcks;
		index = address[`OFFSET_WIDTH +: `INDEX_WIDTH];
		tag = address[`ADDRESS_WIDTH - 1 -: `TAG_WIDTH];
		hit = refStates[index] != cachePackage::INVALID && refTags[index] == tag;
		expReads = hit ? 0 : 4;
		expWritebacks = !hit && refStates[index] == cachePackage::MODIFIED ? 4 : 0;
		expAcks = hit && write && refStates[index] == cachePackage::SHARED ? 1 : 0;
		@(posedge clock);
		startReads = readTotal;
		startWritebacks = writebackTotal;
		startAcks = ackTotal;
		cpuRead <= !write;
		cpuWrite <= write;
		cpuAddress <= address;
		cpuWriteData <= data;
		do @(posedge clock); while (!cpuDone);
		if (!write) begin
			assert (cpuReadData == shadow[address]) else failRun($sformatf(
				"[FAIL] cpuReadData at %h got %h expected %h",
				address, cpuReadData, shadow[address]));
		end
		assert (readTotal - startReads == expReads) else failRun($sformatf(
			"[FAIL] read requests got %h expected %h", readTotal - startReads, expReads));
		assert (writebackTotal - startWritebacks == expWritebacks) else failRun($sformatf(
			"[FAIL] writeback requests got %h expected %h",
			writebackTotal - startWritebacks, expWritebacks));
		assert (ackTotal - startAcks == expAcks) else failRun($sformatf(
			"[FAIL] invalidateAck count got %h expected %h", ackTotal - startAcks, expAcks));
		cpuRead <= 1'b0;
		cpuWrite <= 1'b0;
		if (write) begin
			shadow[address] = data;
			refTags[index] = tag;
			refStates[index] = cachePackage::MODIFIED;
		end else if (!hit) begin
			refTags[index] = tag;
			refStates[index] = cachePackage::SHARED;
		end
		@(posedge clock);
	endtask

	initial begin
		repeat (OPERATIONS * CYCLES_PER_OPERATION) @(posedge clock);
		failRun("watchdog expired before all operations completed");
	end

	initial begin
		logic [15:0] address;
		logic write;
		for (int a = 0; a < (1 << `ADDRESS_WIDTH); a++) begin
			memory[a] = pattern(16'(a));
			shadow[a] = pattern(16'(a));
		end
		for (int i = 0; i < `LINE_COUNT; i++) begin
			refStates[i] = cachePackage::INVALID;
			refTags[i] = '0;
		end
		do @(posedge clock); while (reset);
		// first fill, then hits on the same line
		runOperation(1'b0, 16'h0010, 16'h0);
		runOperation(1'b0, 16'h0011, 16'h0);
		runOperation(1'b0, 16'h0012, 16'h0);
		runOperation(1'b0, 16'h0013, 16'h0);
		runOperation(1'b0, 16'h0010, 16'h0);
		// invalidate, read back, silent second write
		runOperation(1'b1, 16'h0012, 16'hbeef);
		runOperation(1'b0, 16'h0012, 16'h0);
		runOperation(1'b1, 16'h0013, 16'h1234);
		// another tag on the same index evicts the modified line
		runOperation(1'b0, 16'h0030, 16'h0);
		for (int i = 0; i < RANDOM_OPERATIONS; i++) begin
			address = 16'($random(seed)) & 16'h007f;
			write = 1'($random(seed));
			runOperation(write, address, 16'($random(seed)));
		end
		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule : coherentCache_tb

/* coherentCache.f */
+incdir+include
verilog/cachePackage.sv
verilog/cacheArrayInterface.sv
verilog/wordCounter.sv
verilog/cacheArray.sv
verilog/busPort.sv
verilog/cacheController.sv
verilog/coherentCache.sv
bench/clockGenerator.sv
bench/coherentCache_props.sv
bench/coherentCache_tb.sv

/* include/coherentCache_config.svh */
`ifndef COHERENT_CACHE_CONFIG_SVH
`define COHERENT_CACHE_CONFIG_SVH

// word addresses without a byte offset
`define ADDRESS_WIDTH 16
`define DATA_WIDTH 16
`define OFFSET_WIDTH 2
`define INDEX_WIDTH 3
`define TAG_WIDTH (`ADDRESS_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH)
`define LINE_ADDRESS_WIDTH (`ADDRESS_WIDTH - `OFFSET_WIDTH)
`define LINE_COUNT (1 << `INDEX_WIDTH)
`define WORDS_PER_LINE (1 << `OFFSET_WIDTH)
// credits held by the node after reset
`define BUS_CREDITS 2
`define CREDIT_WIDTH 2
`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Iinclude \
	-f coherentCache.f \
	--top-module coherentCache_tb \
	-o coherentCacheSim
./obj_dir/coherentCacheSim

/* verilog/busPort.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module busPort(
	input logic clock, reset,
	input logic start,
	input cachePackage::BusCommand command,
	input logic [`LINE_ADDRESS_WIDTH - 1 : 0] lineAddress,
	input logic [`DATA_WIDTH - 1 : 0] writeWord,
	output logic needWord, wordReturned, finished,
	output logic [`DATA_WIDTH - 1 : 0] returnData,
	output logic busValid,
	output logic [`ADDRESS_WIDTH - 1 : 0] busAddress,
	output logic [`DATA_WIDTH - 1 : 0] busWriteData,
	input logic busCredit, busReadValid,
	input logic [`DATA_WIDTH - 1 : 0] busReadData
);
	logic [`CREDIT_WIDTH - 1 : 0] credits;
	logic [`OFFSET_WIDTH - 1 : 0] requestCount;
	logic requestLast, returnLast;
	logic sentAll, transferCommand, issue;

	assign transferCommand = command == cachePackage::BUS_READ
		|| command == cachePackage::BUS_WRITEBACK;
	// one word request per cycle while a credit is in hand
	assign issue = start && transferCommand && !sentAll && credits != '0;

	assign busValid = issue;
	assign busAddress = {lineAddress, requestCount};
	assign busWriteData = writeWord;
	assign needWord = issue && command == cachePackage::BUS_WRITEBACK;

	assign wordReturned = start && busReadValid && command == cachePackage::BUS_READ;
	assign returnData = busReadData;
	assign finished = command == cachePackage::BUS_WRITEBACK
		? needWord && requestLast : wordReturned && returnLast;

	wordCounter requestCounter(
		.clock(clock), .reset(reset),
		.clear(!start), .advance(issue),
		.count(requestCount), .last(requestLast)
	);

	wordCounter returnCounter(
		.clock(clock), .reset(reset),
		.clear(!start), .advance(wordReturned),
		.count(), .last(returnLast)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= `BUS_CREDITS;
		end else begin
			credits <= credits + `CREDIT_WIDTH'(busCredit) - `CREDIT_WIDTH'(issue);
		end
	end

	// reads stop issuing after four requests until the last word returns
	always_ff @(posedge clock) begin
		if (reset || !start || finished) begin
			sentAll <= 1'b0;
		end else if (issue && requestLast && command == cachePackage::BUS_READ) begin
			sentAll <= 1'b1;
		end
	end
endmodule : busPort

/* verilog/cacheArray.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module cacheArray(
	input logic clock, reset,
	cacheArrayInterface.array port
);
	logic [`TAG_WIDTH - 1 : 0] tags [`LINE_COUNT];
	cachePackage::LineState states [`LINE_COUNT];
	logic [`DATA_WIDTH - 1 : 0] words [`LINE_COUNT][`WORDS_PER_LINE];

	// read side
	assign port.stateOut = states[port.index];
	assign port.tagOut = tags[port.index];
	assign port.dataOut = words[port.index][port.offset];
	assign port.hit = port.stateOut != cachePackage::INVALID && port.tagOut == port.tagIn;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `LINE_COUNT; i++) begin
				states[i] <= cachePackage::INVALID;
			end
		end else if (port.writeState) begin
			states[port.index] <= port.stateIn;
		end
	end

	always_ff @(posedge clock) begin
		if (port.writeTag) begin
			tags[port.index] <= port.tagIn;
		end
	end

	always_ff @(posedge clock) begin
		if (port.writeData) begin
			words[port.index][port.offset] <= port.dataIn;
		end
	end
endmodule : cacheArray

/* verilog/cacheArrayInterface.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

interface cacheArrayInterface;
	logic [`INDEX_WIDTH - 1 : 0] index;
	logic [`TAG_WIDTH - 1 : 0] tagIn;
	logic [`OFFSET_WIDTH - 1 : 0] offset;
	logic [`DATA_WIDTH - 1 : 0] dataIn;
	cachePackage::LineState stateIn;
	// write strobes take effect at the rising edge
	logic writeData, writeTag, writeState;

	logic hit;
	cachePackage::LineState stateOut;
	logic [`TAG_WIDTH - 1 : 0] tagOut;
	logic [`DATA_WIDTH - 1 : 0] dataOut;

	modport controller(
		output index, tagIn, offset, dataIn, stateIn, writeData, writeTag, writeState,
		input hit, stateOut, tagOut, dataOut
	);

	modport array(
		input index, tagIn, offset, dataIn, stateIn, writeData, writeTag, writeState,
		output hit, stateOut, tagOut, dataOut
	);
endinterface : cacheArrayInterface

/* verilog/cacheController.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module cacheController(
	input logic clock, reset,
	input logic cpuRead, cpuWrite,
	input logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input logic [`DATA_WIDTH - 1 : 0] cpuWriteData,
	output logic [`DATA_WIDTH - 1 : 0] cpuReadData,
	output logic cpuDone,
	cacheArrayInterface.controller array,
	output logic counterClear, counterAdvance,
	input logic [`OFFSET_WIDTH - 1 : 0] count,
	input logic last,
	output logic busRequest,
	input logic busGrant, invalidateAck,
	output cachePackage::BusCommand command,
	output logic [`LINE_ADDRESS_WIDTH - 1 : 0] lineAddress,
	output logic start,
	output logic [`DATA_WIDTH - 1 : 0] writeWord,
	input logic needWord, wordReturned, finished,
	input logic [`DATA_WIDTH - 1 : 0] returnData
);
	cachePackage::ControllerState state, nextState;
	cachePackage::BusCommand lookupCommand;
	logic transferring, lookupWriteHit;

	assign transferring = state == cachePackage::WRITEBACK_WORDS
		|| state == cachePackage::FILL_WORDS;

	assign array.index = cpuAddress[`OFFSET_WIDTH +: `INDEX_WIDTH];
	assign array.tagIn = cpuAddress[`ADDRESS_WIDTH - 1 -: `TAG_WIDTH];
	assign array.offset = transferring ? count : cpuAddress[`OFFSET_WIDTH - 1 : 0];
	assign array.dataIn = state == cachePackage::FILL_WORDS ? returnData : cpuWriteData;
	assign array.stateIn = cpuWrite ? cachePackage::MODIFIED : cachePackage::SHARED;

	// a write hit on a modified line is stored during lookup
	assign lookupWriteHit = state == cachePackage::LOOKUP && array.hit && cpuWrite
		&& array.stateOut == cachePackage::MODIFIED;
	assign array.writeData = lookupWriteHit
		|| (state == cachePackage::FILL_WORDS && wordReturned)
		|| (state == cachePackage::COMMIT && cpuWrite);
	assign array.writeTag = state == cachePackage::COMMIT;
	assign array.writeState = state == cachePackage::COMMIT;

	assign cpuDone = state == cachePackage::RESPOND;
	assign cpuReadData = array.dataOut;

	assign counterClear = state == cachePackage::LOOKUP;
	assign counterAdvance = (state == cachePackage::WRITEBACK_WORDS && needWord)
		|| (state == cachePackage::FILL_WORDS && wordReturned);

	assign busRequest = state == cachePackage::ARBITRATE || transferring
		|| state == cachePackage::INVALIDATE_WAIT;
	assign start = transferring;
	assign writeWord = array.dataOut;

	// victim line is addressed by the tag still held in the array
	assign lineAddress = command == cachePackage::BUS_WRITEBACK
		? {array.tagOut, array.index} : {array.tagIn, array.index};

	always_comb begin
		if (!array.hit) begin
			lookupCommand = array.stateOut == cachePackage::MODIFIED
				? cachePackage::BUS_WRITEBACK : cachePackage::BUS_READ;
		end else if (cpuWrite && array.stateOut == cachePackage::SHARED) begin
			lookupCommand = cachePackage::BUS_INVALIDATE;
		end else begin
			lookupCommand = cachePackage::NONE;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			cachePackage::IDLE: begin
				if (cpuRead || cpuWrite) begin
					nextState = cachePackage::LOOKUP;
				end
			end
			cachePackage::LOOKUP: begin
				nextState = lookupCommand == cachePackage::NONE
					? cachePackage::RESPOND : cachePackage::ARBITRATE;
			end
			cachePackage::ARBITRATE: begin
				if (busGrant) begin
					case (command)
						cachePackage::BUS_WRITEBACK: nextState = cachePackage::WRITEBACK_WORDS;
						cachePackage::BUS_INVALIDATE: nextState = cachePackage::INVALIDATE_WAIT;
						default: nextState = cachePackage::FILL_WORDS;
					endcase
				end
			end
			cachePackage::WRITEBACK_WORDS: begin
				// fourth word handed to the bus
				if (needWord && last) begin
					nextState = cachePackage::FILL_WORDS;
				end
			end
			cachePackage::FILL_WORDS: begin
				if (finished) begin
					nextState = cachePackage::COMMIT;
				end
			end
			cachePackage::INVALIDATE_WAIT: begin
				if (invalidateAck && busGrant) begin
					nextState = cachePackage::COMMIT;
				end
			end
			cachePackage::COMMIT: nextState = cachePackage::RESPOND;
			default: nextState = cachePackage::IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= cachePackage::IDLE;
			command <= cachePackage::NONE;
		end else begin
			state <= nextState;
			if (state == cachePackage::LOOKUP) begin
				command <= lookupCommand;
			end else if (state == cachePackage::WRITEBACK_WORDS && needWord && last) begin
				command <= cachePackage::BUS_READ;
			end else if (state == cachePackage::COMMIT) begin
				command <= cachePackage::NONE;
			end
		end
	end
endmodule : cacheController

/* verilog/cachePackage.sv */
package cachePackage;

	typedef enum logic [1:0] {
		INVALID,
		SHARED,
		MODIFIED
	} LineState;

	typedef enum logic [1:0] {
		NONE,
		BUS_READ,
		BUS_WRITEBACK,
		BUS_INVALIDATE
	} BusCommand;

	// controller FSM
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		ARBITRATE,
		WRITEBACK_WORDS,
		FILL_WORDS,
		INVALIDATE_WAIT,
		COMMIT,
		RESPOND
	} ControllerState;
endpackage : cachePackage

/* verilog/coherentCache.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module coherentCache(
	input logic clock, reset,
	input logic cpuRead, cpuWrite,
	input logic [`ADDRESS_WIDTH - 1 : 0] cpuAddress,
	input logic [`DATA_WIDTH - 1 : 0] cpuWriteData,
	output logic [`DATA_WIDTH - 1 : 0] cpuReadData,
	output logic cpuDone,
	output logic busRequest,
	input logic busGrant,
	output cachePackage::BusCommand busCommand,
	output logic [`ADDRESS_WIDTH - 1 : 0] busAddress,
	output logic busValid,
	output logic [`DATA_WIDTH - 1 : 0] busWriteData,
	input logic busCredit, busReadValid,
	input logic [`DATA_WIDTH - 1 : 0] busReadData,
	input logic invalidateAck
);
	cacheArrayInterface arrayBus();

	logic counterClear, counterAdvance, last;
	logic [`OFFSET_WIDTH - 1 : 0] count;
	logic [`LINE_ADDRESS_WIDTH - 1 : 0] lineAddress;
	logic start, needWord, wordReturned, finished;
	logic [`DATA_WIDTH - 1 : 0] writeWord, returnData;

	cacheController controller(
		.clock(clock), .reset(reset),
		.cpuRead(cpuRead), .cpuWrite(cpuWrite),
		.cpuAddress(cpuAddress), .cpuWriteData(cpuWriteData),
		.cpuReadData(cpuReadData), .cpuDone(cpuDone),
		.array(arrayBus.controller),
		.counterClear(counterClear), .counterAdvance(counterAdvance),
		.count(count), .last(last),
		.busRequest(busRequest), .busGrant(busGrant), .invalidateAck(invalidateAck),
		.command(busCommand), .lineAddress(lineAddress), .start(start),
		.writeWord(writeWord), .needWord(needWord), .wordReturned(wordReturned),
		.finished(finished), .returnData(returnData)
	);

	// indexes words as they are written into the array
	wordCounter fillCounter(
		.clock(clock), .reset(reset),
		.clear(counterClear), .advance(counterAdvance),
		.count(count), .last(last)
	);

	cacheArray array(
		.clock(clock), .reset(reset),
		.port(arrayBus.array)
	);

	busPort port(
		.clock(clock), .reset(reset),
		.start(start), .command(busCommand), .lineAddress(lineAddress),
		.writeWord(writeWord), .needWord(needWord), .wordReturned(wordReturned),
		.finished(finished), .returnData(returnData),
		.busValid(busValid), .busAddress(busAddress), .busWriteData(busWriteData),
		.busCredit(busCredit), .busReadValid(busReadValid), .busReadData(busReadData)
	);
endmodule : coherentCache

/* verilog/wordCounter.sv */
`timescale 1ns/1ns
`include "coherentCache_config.svh"

module wordCounter(
	input logic clock, reset,
	input logic clear, advance,
	output logic [`OFFSET_WIDTH - 1 : 0] count,
	output logic last
);
	// wraps to zero after the final word of a line
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (advance) begin
			count <= count + 1'b1;
		end
	end

	assign last = &count;
endmodule : wordCounter
